/* tests/periph_fabric_cases.txt */
# name op(W/R/T) addr wdata strb exp_data exp_resp (hex)
# irq slverr (decimal): expected timer_irq_o after the case, UART model returns SLVERR
uart_wr0      W 40000010 deadbeef f 00000000 0 0 0
uart_rd0      R 40000010 00000000 0 deadbeef 0 0 0
uart_wr_strb  W 40000010 000000aa 1 00000000 0 0 0
uart_rd_strb  R 40000010 00000000 0 deadbeaa 0 0 0
uart_wr_top   W 40001ffc 0badf00d f 00000000 0 0 0
uart_rd_top   R 40001ffc 00000000 0 0badf00d 0 0 0
uart_rd_empty R 40000100 00000000 0 00000000 0 0 0
uart_wr_err   W 40000020 11111111 f 00000000 2 0 1
uart_rd_err   R 40000010 00000000 0 00000000 2 0 1
cmp_lo_wr     W 40010008 12345678 f 00000000 0 0 0
cmp_lo_strb   W 40010008 aabbccdd 3 00000000 0 0 0
cmp_lo_rd     R 40010008 00000000 0 1234ccdd 0 0 0
cmp_hi_strb   W 4001000c 00000000 c 00000000 0 0 0
cmp_hi_rd     R 4001000c 00000000 0 0000ffff 0 0 0
cmp_hi_zero   W 4001000c 00000000 f 00000000 0 0 0
cmp_lo_zero   W 40010008 00000000 f 00000000 0 1 0
cmp_lo_ones   W 40010008 ffffffff f 00000000 0 0 0
cmp_hi_ones   W 4001000c ffffffff f 00000000 0 0 0
time_rd0      T 40010000 00000000 0 00000000 0 0 0
mtime_wr      W 40010000 00000000 f 00000000 0 0 0
time_rd1      T 40010000 00000000 0 00000000 0 0 0
mtime_hi_rd   R 40010004 00000000 0 00000000 0 0 0
decerr_rd     R 50000000 00000000 0 00000000 3 0 0
decerr_wr     W 40002000 12345678 f 00000000 3 0 0
after_decerr  R 40000010 00000000 0 deadbeaa 0 0 0

/* periph_fabric.f */
verilog/periph_pkg.sv
verilog/request_router.sv
verilog/uart_lite_bridge.sv
verilog/machine_timer.sv
verilog/response_merge.sv
verilog/periph_fabric.sv
tests/periph_fabric_chk.sv
tests/periph_fabric_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the periph_fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_fabric_tb -f periph_fabric.f \
    -o periph_fabric_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/periph_fabric_sim > sim.log 2>&1 \
    || { echo "Simulation stopped abnormally, see sim.log"; exit 1; }

grep -q "Done: errors found" sim.log \
    && { echo "FAIL, see sim.log"; exit 1; }

grep -q "Done: no errors" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, no result line in sim.log"; exit 1; }

/* tests/periph_fabric_tb.sv */
`timescale 1ns/1ps

module periph_fabric_tb
    import periph_pkg::*;
();

    localparam int MAX_CASES   = 64;
    localparam int CASE_CYCLES = 100;
    localparam int CLK_PERIOD  = 20;
    localparam int MEM_WORDS   = 2 ** (UART_ADDR_W - 2);

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   req_valid_i;
    logic                   req_write_i;
    addr_t                  req_addr_i;
    word_t                  req_wdata_i;
    strb_t                  req_strb_i;
    logic                   req_ready_o;
    logic                   rsp_valid_o;
    word_t                  rsp_rdata_o;
    resp_e                  rsp_resp_o;
    logic [UART_ADDR_W-1:0] uart_awaddr_o;
    logic                   uart_awvalid_o;
    logic                   uart_awready_i;
    word_t                  uart_wdata_o;
    strb_t                  uart_wstrb_o;
    logic                   uart_wvalid_o;
    logic                   uart_wready_i;
    logic [1:0]             uart_bresp_i;
    logic                   uart_bvalid_i;
    logic                   uart_bready_o;
    logic [UART_ADDR_W-1:0] uart_araddr_o;
    logic                   uart_arvalid_o;
    logic                   uart_arready_i;
    word_t                  uart_rdata_i;
    logic [1:0]             uart_rresp_i;
    logic                   uart_rvalid_i;
    logic                   uart_rready_o;
    time_t                  time_o;
    logic                   timer_irq_o;

    // Case table
    string c_name   [MAX_CASES];
    string c_op     [MAX_CASES];
    addr_t c_addr   [MAX_CASES];
    word_t c_wdata  [MAX_CASES];
    strb_t c_strb   [MAX_CASES];
    word_t c_exp    [MAX_CASES];
    resp_e c_resp   [MAX_CASES];
    bit    c_irq    [MAX_CASES];
    bit    c_slverr [MAX_CASES];
    int    n_cases = 0;
    bit    cases_loaded = 1'b0;

    int    errors = 0;
    int    failed = 0;
    int    seed = 32'h6315_ff9b;
    word_t prev_time;
    bit    have_time = 1'b0;
    time   rst_release = 0;

    // Shared with the UART slave model
    logic [UART_ADDR_W-1:0] exp_uart_addr;
    bit                     inject_err;
    word_t                  uart_mem     [MEM_WORDS];
    bit                     uart_written [MEM_WORDS];

    periph_fabric periph_fabric_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        wait (cases_loaded);
        #((n_cases + 1) * CASE_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all cases finished");
        $display("Done: errors found");
        $finish;
    end

    function automatic int pick_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Error: %0s data expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input resp_e exp, input resp_e act);
        if (act !== exp) begin
            $display("Error: %0s response expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_irq(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            $display("Error: %0s timer_irq expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_time(input string name, input time_t exp, input time_t act);
        if (act !== exp) begin
            $display("Error: %0s time_o expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          cnt;
        string       line;
        string       t_name;
        string       t_op;
        logic [31:0] t_addr;
        logic [31:0] t_wdata;
        logic [31:0] t_strb;
        logic [31:0] t_data;
        logic [31:0] t_resp;
        int          t_irq;
        int          t_err;
        fd = $fopen("tests/periph_fabric_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file");
            errors++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            cnt = $fgets(line, fd);
            cnt = $sscanf(line, "%s %s %h %h %h %h %h %d %d", t_name, t_op, t_addr,
                          t_wdata, t_strb, t_data, t_resp, t_irq, t_err);
            // Comment and blank lines do not parse fully
            if (cnt == 9) begin
                c_name[n_cases]   = t_name;
                c_op[n_cases]     = t_op;
                c_addr[n_cases]   = t_addr;
                c_wdata[n_cases]  = t_wdata;
                c_strb[n_cases]   = t_strb[STRB_W-1:0];
                c_exp[n_cases]    = t_data;
                c_resp[n_cases]   = resp_e'(t_resp[1:0]);
                c_irq[n_cases]    = (t_irq != 0);
                c_slverr[n_cases] = (t_err != 0);
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    task automatic serve_write();
        int    aw_wait;
        int    w_wait;
        bit    aw_done;
        bit    w_done;
        int    idx;
        word_t word;
        aw_wait = pick_delay();
        w_wait  = pick_delay();
        aw_done = 1'b0;
        w_done  = 1'b0;
        idx     = int'(uart_awaddr_o[UART_ADDR_W-1:2]);
        if (uart_awaddr_o !== exp_uart_addr) begin
            $display("UART write address %h is not the window offset %h",
                     uart_awaddr_o, exp_uart_addr);
            errors++;
        end
        // aw and w accepted independently
        while (!(aw_done && w_done)) begin
            uart_awready_i = !aw_done && (aw_wait == 0);
            uart_wready_i  = !w_done && (w_wait == 0);
            @(negedge clk_i);
            if (uart_awready_i) begin
                aw_done = 1'b1;
            end
            if (uart_wready_i) begin
                w_done = 1'b1;
            end
            aw_wait--;
            w_wait--;
        end
        uart_awready_i = 1'b0;
        uart_wready_i  = 1'b0;
        if (!inject_err) begin
            word = uart_written[idx] ? uart_mem[idx] : '0;
            for (int b = 0; b < STRB_W; b++) begin
                if (uart_wstrb_o[b]) begin
                    word[8*b +: 8] = uart_wdata_o[8*b +: 8];
                end
            end
            uart_mem[idx]     = word;
            uart_written[idx] = 1'b1;
        end
        repeat (pick_delay()) @(negedge clk_i);
        uart_bresp_i  = inject_err ? 2'b10 : 2'b00;
        uart_bvalid_i = 1'b1;
        while (!uart_bready_o) @(negedge clk_i);
        @(negedge clk_i);
        uart_bvalid_i = 1'b0;
    endtask

    task automatic serve_read();
        int idx;
        idx = int'(uart_araddr_o[UART_ADDR_W-1:2]);
        if (uart_araddr_o !== exp_uart_addr) begin
            $display("UART read address %h is not the window offset %h",
                     uart_araddr_o, exp_uart_addr);
            errors++;
        end
        repeat (pick_delay()) @(negedge clk_i);
        uart_arready_i = 1'b1;
        @(negedge clk_i);
        uart_arready_i = 1'b0;
        repeat (pick_delay()) @(negedge clk_i);
        uart_rresp_i  = inject_err ? 2'b10 : 2'b00;
        uart_rdata_i  = (!inject_err && uart_written[idx]) ? uart_mem[idx] : '0;
        uart_rvalid_i = 1'b1;
        while (!uart_rready_o) @(negedge clk_i);
        @(negedge clk_i);
        uart_rvalid_i = 1'b0;
    endtask

    // UART slave model
    initial begin
        wait (rst_n_i);
        forever begin
            @(negedge clk_i);
            if (uart_awvalid_o && uart_wvalid_o) begin
                serve_write();
            end else if (uart_arvalid_o) begin
                serve_read();
            end
        end
    end

    task automatic run_case(input int i);
        int    cycles;
        int    err_before;
        bit    is_uart;
        addr_t offset;
        word_t rdata;
        resp_e resp;
        err_before    = errors;
        is_uart       = (c_addr[i] >= UART_BASE) && (c_addr[i] <= UART_END);
        offset        = c_addr[i] - UART_BASE;
        exp_uart_addr = offset[UART_ADDR_W-1:0];
        inject_err    = c_slverr[i];
        req_valid_i   = 1'b1;
        req_write_i   = (c_op[i] == "W");
        req_addr_i    = c_addr[i];
        req_wdata_i   = c_wdata[i];
        req_strb_i    = c_strb[i];
        cycles = 0;
        while (!req_ready_o && cycles < CASE_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        // Accept edge lies between these two falling edges
        @(negedge clk_i);
        req_valid_i = 1'b0;
        cycles = 1;
        while (!rsp_valid_o && cycles < CASE_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!rsp_valid_o) begin
            $display("%0s got no response within %0d cycles", c_name[i], CASE_CYCLES);
            errors++;
        end else begin
            rdata = rsp_rdata_o;
            resp  = rsp_resp_o;
            if (c_op[i] == "T") begin
                if (have_time && rdata <= prev_time) begin
                    $display("%0s time %h did not rise above %h", c_name[i], rdata, prev_time);
                    errors++;
                end
                prev_time = rdata;
                have_time = 1'b1;
            end else begin
                check_word(c_name[i], c_exp[i], rdata);
            end
            check_resp(c_name[i], c_resp[i], resp);
            if (!is_uart && cycles != 3) begin
                $display("Error: %0s latency expected 3 actual %0d", c_name[i], cycles);
                errors++;
            end
        end
        @(negedge clk_i);
        if (!req_ready_o) begin
            $display("%0s left the request port not ready", c_name[i]);
            errors++;
        end
        check_irq(c_name[i], c_irq[i], timer_irq_o);
        // One count per rising edge since reset was released
        check_time(c_name[i], time_t'(($time - rst_release) / CLK_PERIOD), time_o);
        if (errors != err_before) begin
            failed++;
        end
        $display("%0s: %0s", c_name[i], (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        rst_n_i        = 1'b0;
        req_valid_i    = 1'b0;
        req_write_i    = 1'b0;
        req_addr_i     = '0;
        req_wdata_i    = '0;
        req_strb_i     = '0;
        uart_awready_i = 1'b0;
        uart_wready_i  = 1'b0;
        uart_bresp_i   = 2'b00;
        uart_bvalid_i  = 1'b0;
        uart_arready_i = 1'b0;
        uart_rdata_i   = '0;
        uart_rresp_i   = 2'b00;
        uart_rvalid_i  = 1'b0;
        exp_uart_addr  = '0;
        inject_err     = 1'b0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;
        rst_release = $time;
        @(negedge clk_i);
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        if (n_cases == 0) begin
            $display("No cases were loaded");
            errors++;
        end
        $display("Cases run %0d, failed %0d, errors %0d", n_cases, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tests/periph_fabric_chk.sv */
`timescale 1ns/1ps

module periph_fabric_chk (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_valid_i,
    input logic req_ready_o,
    input logic rsp_valid_o,
    input logic uart_awvalid_o,
    input logic uart_awready_i,
    input logic timer_irq_o
);

    logic pending_q;

    // Accepted request still waiting for its response
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            pending_q <= 1'b1;
        end else if (rsp_valid_o) begin
            pending_q <= 1'b0;
        end
    end

    rsp_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o |=> !rsp_valid_o)
        else $error("rsp_valid_o high for two cycles");

    ready_low_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pending_q |-> !req_ready_o)
        else $error("req_ready_o high while a response is pending");

    awvalid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (uart_awvalid_o && !uart_awready_i) |=> uart_awvalid_o)
        else $error("uart_awvalid_o dropped before uart_awready_i");

    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (!rsp_valid_o && !timer_irq_o))
        else $error("rsp_valid_o or timer_irq_o high right after reset");

endmodule

bind periph_fabric periph_fabric_chk periph_fabric_chk_inst (.*);

/* verilog/periph_fabric.sv */
`timescale 1ns/1ps

module periph_fabric
    import periph_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   req_valid_i,
    input  logic                   req_write_i,
    input  addr_t                  req_addr_i,
    input  word_t                  req_wdata_i,
    input  strb_t                  req_strb_i,
    output logic                   req_ready_o,

    output logic                   rsp_valid_o,
    output word_t                  rsp_rdata_o,
    output resp_e                  rsp_resp_o,

    output logic [UART_ADDR_W-1:0] uart_awaddr_o,
    output logic                   uart_awvalid_o,
    input  logic                   uart_awready_i,
    output word_t                  uart_wdata_o,
    output strb_t                  uart_wstrb_o,
    output logic                   uart_wvalid_o,
    input  logic                   uart_wready_i,
    input  logic [1:0]             uart_bresp_i,
    input  logic                   uart_bvalid_i,
    output logic                   uart_bready_o,
    output logic [UART_ADDR_W-1:0] uart_araddr_o,
    output logic                   uart_arvalid_o,
    input  logic                   uart_arready_i,
    input  word_t                  uart_rdata_i,
    input  logic [1:0]             uart_rresp_i,
    input  logic                   uart_rvalid_i,
    output logic                   uart_rready_o,

    output time_t                  time_o,
    output logic                   timer_irq_o
);

    logic    uart_start;
    logic    timer_start;
    logic    none_start;
    target_e target;
    logic    req_write;
    addr_t   req_addr;
    word_t   req_wdata;
    strb_t   req_strb;
    logic    uart_done;
    word_t   uart_rdata;
    resp_e   uart_resp;
    logic    timer_done;
    word_t   timer_rdata;
    resp_e   timer_resp;

    request_router request_router_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_write_i   (req_write_i),
        .req_addr_i    (req_addr_i),
        .req_wdata_i   (req_wdata_i),
        .req_strb_i    (req_strb_i),
        .done_i        (rsp_valid_o),
        .req_ready_o   (req_ready_o),
        .uart_start_o  (uart_start),
        .timer_start_o (timer_start),
        .none_start_o  (none_start),
        .target_o      (target),
        .write_o       (req_write),
        .addr_o        (req_addr),
        .wdata_o       (req_wdata),
        .strb_o        (req_strb)
    );

    uart_lite_bridge uart_lite_bridge_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .start_i        (uart_start),
        .write_i        (req_write),
        .addr_i         (req_addr),
        .wdata_i        (req_wdata),
        .strb_i         (req_strb),
        .done_o         (uart_done),
        .rdata_o        (uart_rdata),
        .resp_o         (uart_resp),
        .uart_awaddr_o  (uart_awaddr_o),
        .uart_awvalid_o (uart_awvalid_o),
        .uart_awready_i (uart_awready_i),
        .uart_wdata_o   (uart_wdata_o),
        .uart_wstrb_o   (uart_wstrb_o),
        .uart_wvalid_o  (uart_wvalid_o),
        .uart_wready_i  (uart_wready_i),
        .uart_bresp_i   (uart_bresp_i),
        .uart_bvalid_i  (uart_bvalid_i),
        .uart_bready_o  (uart_bready_o),
        .uart_araddr_o  (uart_araddr_o),
        .uart_arvalid_o (uart_arvalid_o),
        .uart_arready_i (uart_arready_i),
        .uart_rdata_i   (uart_rdata_i),
        .uart_rresp_i   (uart_rresp_i),
        .uart_rvalid_i  (uart_rvalid_i),
        .uart_rready_o  (uart_rready_o)
    );

    machine_timer machine_timer_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (timer_start),
        .write_i (req_write),
        .addr_i  (req_addr),
        .wdata_i (req_wdata),
        .strb_i  (req_strb),
        .done_o  (timer_done),
        .rdata_o (timer_rdata),
        .resp_o  (timer_resp),
        .time_o  (time_o),
        .irq_o   (timer_irq_o)
    );

    response_merge response_merge_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .target_i      (target),
        .none_start_i  (none_start),
        .uart_done_i   (uart_done),
        .uart_rdata_i  (uart_rdata),
        .uart_resp_i   (uart_resp),
        .timer_done_i  (timer_done),
        .timer_rdata_i (timer_rdata),
        .timer_resp_i  (timer_resp),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_rdata_o   (rsp_rdata_o),
        .rsp_resp_o    (rsp_resp_o)
    );

endmodule

/* verilog/response_merge.sv */
`timescale 1ns/1ps

module response_merge
    import periph_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    input  target_e target_i,
    input  logic    none_start_i,
    input  logic    uart_done_i,
    input  word_t   uart_rdata_i,
    input  resp_e   uart_resp_i,
    input  logic    timer_done_i,
    input  word_t   timer_rdata_i,
    input  resp_e   timer_resp_i,

    output logic    rsp_valid_o,
    output word_t   rsp_rdata_o,
    output resp_e   rsp_resp_o
);

    logic  take_uart;
    logic  take_timer;
    logic  none_done_q;
    logic  rsp_valid_q;
    word_t rsp_rdata_q;
    resp_e rsp_resp_q;

    // Done only counts from the target that was decoded
    assign take_uart  = uart_done_i && (target_i == TGT_UART);
    assign take_timer = timer_done_i && (target_i == TGT_TIMER);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            none_done_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            // Decode error takes as long as a timer access
            none_done_q <= none_start_i;
            rsp_valid_q <= take_uart || take_timer || none_done_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_uart) begin
            rsp_rdata_q <= uart_rdata_i;
            rsp_resp_q  <= uart_resp_i;
        end else if (take_timer) begin
            rsp_rdata_q <= timer_rdata_i;
            rsp_resp_q  <= timer_resp_i;
        end else if (none_done_q) begin
            rsp_rdata_q <= '0;
            rsp_resp_q  <= RESP_DECERR;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_resp_o  = rsp_resp_q;

endmodule

/* verilog/machine_timer.sv */
`timescale 1ns/1ps

module machine_timer
    import periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,

    input  logic  start_i,
    input  logic  write_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    input  strb_t strb_i,
    output logic  done_o,
    output word_t rdata_o,
    output resp_e resp_o,

    output time_t time_o,
    output logic  irq_o
);

    time_t                  mtime_q;
    time_t                  cmp_q;
    logic                   irq_q;
    logic                   done_q;
    word_t                  rdata_q;
    resp_e                  resp_q;
    addr_t                  offset;
    logic [TIMER_OFS_W-1:0] reg_ofs;
    logic                   aligned;
    logic                   wr_en;

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t strb);
        word_t res;
        res = old_w;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign offset  = addr_i - TIMER_BASE;
    assign reg_ofs = {offset[TIMER_OFS_W-1:2], 2'b00};
    assign aligned = (offset[1:0] == 2'b00);
    assign wr_en   = start_i && write_i && aligned;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtime_q <= '0;
            cmp_q   <= '1;
            irq_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
            irq_q   <= (mtime_q >= cmp_q);
            done_q  <= start_i;
            // Time registers are read only
            if (wr_en && reg_ofs == TIMER_CMP_LO) begin
                cmp_q[DATA_W-1:0] <= merge_bytes(cmp_q[DATA_W-1:0], wdata_i, strb_i);
            end else if (wr_en && reg_ofs == TIMER_CMP_HI) begin
                cmp_q[TIME_W-1:DATA_W] <= merge_bytes(cmp_q[TIME_W-1:DATA_W], wdata_i, strb_i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            resp_q  <= aligned ? RESP_OKAY : RESP_SLVERR;
            rdata_q <= '0;
            if (!write_i && aligned) begin
                case (reg_ofs)
                    TIMER_MTIME_LO: rdata_q <= mtime_q[DATA_W-1:0];
                    TIMER_MTIME_HI: rdata_q <= mtime_q[TIME_W-1:DATA_W];
                    TIMER_CMP_LO:   rdata_q <= cmp_q[DATA_W-1:0];
                    TIMER_CMP_HI:   rdata_q <= cmp_q[TIME_W-1:DATA_W];
                    default:        rdata_q <= '0;
                endcase
            end
        end
    end

    assign done_o  = done_q;
    assign rdata_o = rdata_q;
    assign resp_o  = resp_q;
    assign time_o  = mtime_q;
    assign irq_o   = irq_q;

endmodule

/* verilog/uart_lite_bridge.sv */
`timescale 1ns/1ps

module uart_lite_bridge
    import periph_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   start_i,
    input  logic                   write_i,
    input  addr_t                  addr_i,
    input  word_t                  wdata_i,
    input  strb_t                  strb_i,
    output logic                   done_o,
    output word_t                  rdata_o,
    output resp_e                  resp_o,

    output logic [UART_ADDR_W-1:0] uart_awaddr_o,
    output logic                   uart_awvalid_o,
    input  logic                   uart_awready_i,
    output word_t                  uart_wdata_o,
    output strb_t                  uart_wstrb_o,
    output logic                   uart_wvalid_o,
    input  logic                   uart_wready_i,
    input  logic [1:0]             uart_bresp_i,
    input  logic                   uart_bvalid_i,
    output logic                   uart_bready_o,
    output logic [UART_ADDR_W-1:0] uart_araddr_o,
    output logic                   uart_arvalid_o,
    input  logic                   uart_arready_i,
    input  word_t                  uart_rdata_i,
    input  logic [1:0]             uart_rresp_i,
    input  logic                   uart_rvalid_i,
    output logic                   uart_rready_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE,
        ST_BRESP,
        ST_ADDR,
        ST_RDATA
    } state_e;

    state_e state_q;
    logic   awvalid_q;
    logic   wvalid_q;
    logic   bready_q;
    logic   arvalid_q;
    logic   rready_q;
    logic   done_q;
    word_t  rdata_q;
    resp_e  resp_q;
    addr_t  offset;
    logic   aw_ok;
    logic   w_ok;

    // Window-relative address
    assign offset = addr_i - UART_BASE;

    // Channel accepted now or earlier
    assign aw_ok = !awvalid_q || uart_awready_i;
    assign w_ok  = !wvalid_q || uart_wready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            bready_q  <= 1'b0;
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_i && write_i) begin
                        awvalid_q <= 1'b1;
                        wvalid_q  <= 1'b1;
                        state_q   <= ST_WRITE;
                    end else if (start_i) begin
                        arvalid_q <= 1'b1;
                        state_q   <= ST_ADDR;
                    end
                end
                ST_WRITE: begin
                    if (uart_awready_i) awvalid_q <= 1'b0;
                    if (uart_wready_i) wvalid_q <= 1'b0;
                    if (aw_ok && w_ok) begin
                        bready_q <= 1'b1;
                        state_q  <= ST_BRESP;
                    end
                end
                ST_BRESP: begin
                    if (uart_bvalid_i) begin
                        bready_q <= 1'b0;
                        done_q   <= 1'b1;
                        state_q  <= ST_IDLE;
                    end
                end
                ST_ADDR: begin
                    if (uart_arready_i) begin
                        arvalid_q <= 1'b0;
                        rready_q  <= 1'b1;
                        state_q   <= ST_RDATA;
                    end
                end
                ST_RDATA: begin
                    if (uart_rvalid_i) begin
                        rready_q <= 1'b0;
                        done_q   <= 1'b1;
                        state_q  <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Capture the returned response
    always_ff @(posedge clk_i) begin
        if (state_q == ST_BRESP && uart_bvalid_i) begin
            rdata_q <= '0;
            resp_q  <= resp_e'(uart_bresp_i);
        end else if (state_q == ST_RDATA && uart_rvalid_i) begin
            rdata_q <= uart_rdata_i;
            resp_q  <= resp_e'(uart_rresp_i);
        end
    end

    assign uart_awaddr_o  = offset[UART_ADDR_W-1:0];
    assign uart_araddr_o  = offset[UART_ADDR_W-1:0];
    assign uart_wdata_o   = wdata_i;
    assign uart_wstrb_o   = strb_i;
    assign uart_awvalid_o = awvalid_q;
    assign uart_wvalid_o  = wvalid_q;
    assign uart_bready_o  = bready_q;
    assign uart_arvalid_o = arvalid_q;
    assign uart_rready_o  = rready_q;
    assign done_o         = done_q;
    assign rdata_o        = rdata_q;
    assign resp_o         = resp_q;

endmodule

/* verilog/request_router.sv */
`timescale 1ns/1ps

module request_router
    import periph_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    input  logic    req_valid_i,
    input  logic    req_write_i,
    input  addr_t   req_addr_i,
    input  word_t   req_wdata_i,
    input  strb_t   req_strb_i,
    input  logic    done_i,
    output logic    req_ready_o,

    output logic    uart_start_o,
    output logic    timer_start_o,
    output logic    none_start_o,
    output target_e target_o,
    output logic    write_o,
    output addr_t   addr_o,
    output word_t   wdata_o,
    output strb_t   strb_o
);

    logic    busy_q;
    logic    accept;
    logic    hit_uart;
    logic    hit_timer;
    logic    uart_start_q;
    logic    timer_start_q;
    logic    none_start_q;
    target_e target_q;
    logic    write_q;
    addr_t   addr_q;
    word_t   wdata_q;
    strb_t   strb_q;

    // Only one transaction in flight
    assign accept    = req_valid_i && !busy_q;
    assign hit_uart  = (req_addr_i >= UART_BASE) && (req_addr_i <= UART_END);
    assign hit_timer = (req_addr_i >= TIMER_BASE) && (req_addr_i <= TIMER_END);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q        <= 1'b0;
            uart_start_q  <= 1'b0;
            timer_start_q <= 1'b0;
            none_start_q  <= 1'b0;
            target_q      <= TGT_NONE;
        end else begin
            uart_start_q  <= accept && hit_uart;
            timer_start_q <= accept && hit_timer;
            none_start_q  <= accept && !hit_uart && !hit_timer;
            if (accept) begin
                busy_q   <= 1'b1;
                target_q <= hit_uart ? TGT_UART : (hit_timer ? TGT_TIMER : TGT_NONE);
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Request fields held until the next accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            write_q <= req_write_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            strb_q  <= req_strb_i;
        end
    end

    assign req_ready_o   = !busy_q;
    assign uart_start_o  = uart_start_q;
    assign timer_start_o = timer_start_q;
    assign none_start_o  = none_start_q;
    assign target_o      = target_q;
    assign write_o       = write_q;
    assign addr_o        = addr_q;
    assign wdata_o       = wdata_q;
    assign strb_o        = strb_q;

endmodule

/* verilog/periph_pkg.sv */
package periph_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int STRB_W      = DATA_W / 8;
    localparam int TIME_W      = 64;
    localparam int UART_ADDR_W = 13;
    localparam int TIMER_OFS_W = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [TIME_W-1:0] time_t;

    // Address map
    localparam addr_t UART_BASE  = 32'h4000_0000;
    localparam addr_t UART_END   = 32'h4000_1FFF;
    localparam addr_t TIMER_BASE = 32'h4001_0000;
    localparam addr_t TIMER_END  = 32'h4001_000F;

    // Timer register offsets
    localparam logic [TIMER_OFS_W-1:0] TIMER_MTIME_LO = 4'h0;
    localparam logic [TIMER_OFS_W-1:0] TIMER_MTIME_HI = 4'h4;
    localparam logic [TIMER_OFS_W-1:0] TIMER_CMP_LO   = 4'h8;
    localparam logic [TIMER_OFS_W-1:0] TIMER_CMP_HI   = 4'hC;

    // AXI response coding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef enum logic [1:0] {
        TGT_UART  = 2'd0,
        TGT_TIMER = 2'd1,
        TGT_NONE  = 2'd2
    } target_e;

endpackage
